// File: Makefile
# Verilator flow for the debug system control testbench.
TOP := dbg_scm_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

# the run log is searched for the fail message; a crashed run also fails.
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1; \
	status=$$?; \
	cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: build.f
design/dbg_pkg.sv
design/dbg_flit_fifo.sv
design/dbg_reg_access.sv
design/dbg_scm.sv
design/dbg_scm_top.sv
test/dbg_scm_props.sv
test/dbg_scm_tb.sv

// File: design/dbg_flit_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fall-through flit buffer; the head is valid the cycle after a write.
// accepts a write while full only if the head is read in that cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module dbg_flit_fifo import dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // host side.
  input  flit_data_t debug_in_data,
  input  logic       debug_in_last,
  input  logic       debug_in_valid,
  output logic       debug_in_ready,
  // engine side.
  output flit_data_t fifo_data,
  output logic       fifo_last,
  output logic       fifo_valid,
  input  logic       fifo_ready
);

  // flit words and their last bits.
  flit_data_t         data_mem [FIFO_DEPTH];
  logic               last_mem [FIFO_DEPTH];

  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  // one bit wider than the pointers to hold a full count.
  logic [FIFO_AW:0]   count;

  logic full;
  logic wr_en;
  logic rd_en;

  assign full = (int'(count) == FIFO_DEPTH);

  // a pop in the same cycle frees the slot.
  assign debug_in_ready = ~full | fifo_ready;

  // head of the buffer.
  assign fifo_valid = (count != '0);
  assign fifo_data  = data_mem[rd_ptr];
  assign fifo_last  = last_mem[rd_ptr];

  assign wr_en = debug_in_valid & debug_in_ready;
  assign rd_en = fifo_valid & fifo_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[wr_ptr] <= debug_in_data;
      last_mem[wr_ptr] <= debug_in_last;
    end
  end

  // pointers wrap on their own as the depth is a power of two.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // count moves only when one side acts alone.
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: design/dbg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, packet codes and identity values of the debug module.
// only 16-bit register packets are defined; no event or trace codes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dbg_pkg;

  // one word on the debug flit stream.
  typedef logic [15:0] flit_data_t;
  // register address and data, both one flit wide.
  typedef logic [15:0] reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // packet field codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // type sits in flags[15:14], subtype in flags[13:10].
  localparam logic [1:0] TYPE_REG           = 2'b00;
  localparam logic [3:0] SUB_REQ_READ       = 4'b0000;
  localparam logic [3:0] SUB_REQ_WRITE      = 4'b0100;
  localparam logic [3:0] SUB_RESP_READ_OK   = 4'b1000;
  localparam logic [3:0] SUB_RESP_READ_ERR  = 4'b1100;
  localparam logic [3:0] SUB_RESP_WRITE_OK  = 4'b1010;
  localparam logic [3:0] SUB_RESP_WRITE_ERR = 4'b1110;

  // generic module identity, served at 0x0000 to 0x0002.
  localparam reg_data_t MOD_VENDOR  = 16'h0001;
  localparam reg_data_t MOD_TYPE    = 16'h0001;
  localparam reg_data_t MOD_VERSION = 16'h0000;

  // system identity, served at 0x0200 to 0x0203.
  localparam reg_data_t SYSTEM_VENDOR_ID = 16'h0001;
  localparam reg_data_t SYSTEM_DEVICE_ID = 16'h00a5;
  localparam reg_data_t NUM_MOD          = 16'h0003;
  localparam reg_data_t MAX_PKT_LEN      = 16'h000c;

  // system control window starts here.
  localparam reg_addr_t SCM_BASE_ADDR = 16'h0200;
  localparam reg_addr_t RST_VEC_ADDR  = 16'h0204;

  // input buffer depth, a power of two.
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_AW    = $clog2(FIFO_DEPTH);

  // register access engine states.
  typedef enum logic [3:0] {
    ST_DEST, ST_SRC, ST_FLAGS, ST_ADDR, ST_WDATA, ST_DROP, ST_ACCESS,
    ST_RESP_DEST, ST_RESP_SRC, ST_RESP_FLAGS, ST_RESP_DATA
  } req_state_t;

endpackage

// File: design/dbg_reg_access.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16-bit register request parser and responder; one packet in flight.
// foreign or unsupported packets are dropped without a response.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module dbg_reg_access import dbg_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] id,
  // request flits from the buffer.
  input  flit_data_t  fifo_data,
  input  logic        fifo_last,
  input  logic        fifo_valid,
  output logic        fifo_ready,
  // response flits to the host.
  output flit_data_t  debug_out_data,
  output logic        debug_out_last,
  output logic        debug_out_valid,
  input  logic        debug_out_ready,
  // strobe to the system control module.
  output logic        reg_request,
  output logic        reg_write,
  output reg_addr_t   reg_addr,
  output reg_data_t   reg_wdata,
  input  logic        reg_err,
  input  reg_data_t   reg_rdata
);

  req_state_t state;

  // captured request fields.
  flit_data_t src_q;
  logic       write_q;
  reg_addr_t  addr_q;
  reg_data_t  wdata_q;
  // result of the access cycle.
  logic       resp_err_q;
  reg_data_t  resp_data_q;

  logic       in_take;
  logic       out_take;
  logic       flags_ok;
  logic       is_scm;
  logic       base_err;
  reg_data_t  base_rdata;
  logic [3:0] resp_sub;

  // input is taken only while parsing or dropping.
  assign fifo_ready = state inside {ST_DEST, ST_SRC, ST_FLAGS, ST_ADDR, ST_WDATA, ST_DROP};
  assign in_take    = fifo_valid & fifo_ready;
  assign out_take   = debug_out_valid & debug_out_ready;

  // only 16-bit reads and writes of register type.
  assign flags_ok = (fifo_data[15:14] == TYPE_REG) &&
                    ((fifo_data[13:10] == SUB_REQ_READ) ||
                     (fifo_data[13:10] == SUB_REQ_WRITE));

  assign is_scm      = (addr_q >= SCM_BASE_ADDR);
  assign reg_request = (state == ST_ACCESS) & is_scm;
  assign reg_write   = write_q;
  assign reg_addr    = addr_q;
  assign reg_wdata   = wdata_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // base registers below the system window
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    base_err   = 1'b0;
    base_rdata = '0;
    case (addr_q)
      16'h0000: base_rdata = MOD_VENDOR;
      16'h0001: base_rdata = MOD_TYPE;
      16'h0002: base_rdata = MOD_VERSION;
      default:  base_err   = 1'b1;
    endcase
    // identity registers are read only.
    if (write_q) begin
      base_err = 1'b1;
    end
  end

  always_comb begin
    case ({write_q, resp_err_q})
      2'b00:   resp_sub = SUB_RESP_READ_OK;
      2'b01:   resp_sub = SUB_RESP_READ_ERR;
      2'b10:   resp_sub = SUB_RESP_WRITE_OK;
      default: resp_sub = SUB_RESP_WRITE_ERR;
    endcase
  end

  // response flit mux, driven straight from state.
  always_comb begin
    debug_out_valid = 1'b0;
    debug_out_data  = '0;
    debug_out_last  = 1'b0;
    case (state)
      ST_RESP_DEST: begin
        debug_out_valid = 1'b1;
        debug_out_data  = src_q;
      end
      ST_RESP_SRC: begin
        debug_out_valid = 1'b1;
        debug_out_data  = id;
      end
      ST_RESP_FLAGS: begin
        debug_out_valid = 1'b1;
        debug_out_data  = {TYPE_REG, resp_sub, 10'h000};
        // no data flit after writes or errors.
        debug_out_last  = write_q | resp_err_q;
      end
      ST_RESP_DATA: begin
        debug_out_valid = 1'b1;
        debug_out_data  = resp_data_q;
        debug_out_last  = 1'b1;
      end
      default: ;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // a packet ending early falls back to ST_DEST.
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_DEST;
    end else begin
      case (state)
        ST_DEST:  if (in_take && !fifo_last) state <= (fifo_data == id) ? ST_SRC : ST_DROP;
        ST_SRC:   if (in_take) state <= fifo_last ? ST_DEST : ST_FLAGS;
        ST_FLAGS: if (in_take) state <= fifo_last ? ST_DEST : (flags_ok ? ST_ADDR : ST_DROP);
        ST_ADDR: begin
          if (in_take && write_q) state <= fifo_last ? ST_DEST : ST_WDATA;
          else if (in_take)       state <= fifo_last ? ST_ACCESS : ST_DROP;
        end
        ST_WDATA:      if (in_take) state <= fifo_last ? ST_ACCESS : ST_DROP;
        ST_DROP:       if (in_take && fifo_last) state <= ST_DEST;
        ST_ACCESS:     state <= ST_RESP_DEST;
        ST_RESP_DEST:  if (out_take) state <= ST_RESP_SRC;
        ST_RESP_SRC:   if (out_take) state <= ST_RESP_FLAGS;
        ST_RESP_FLAGS: if (out_take) state <= debug_out_last ? ST_DEST : ST_RESP_DATA;
        ST_RESP_DATA:  if (out_take) state <= ST_DEST;
        default:       state <= ST_DEST;
      endcase
    end
  end

  // field capture and access result.
  always_ff @(posedge clk) begin
    if (in_take && state == ST_SRC)   src_q   <= fifo_data;
    if (in_take && state == ST_FLAGS) write_q <= (fifo_data[13:10] == SUB_REQ_WRITE);
    if (in_take && state == ST_ADDR)  addr_q  <= fifo_data;
    if (in_take && state == ST_WDATA) wdata_q <= fifo_data;
    if (state == ST_ACCESS) begin
      resp_err_q  <= is_scm ? reg_err : base_err;
      resp_data_q <= is_scm ? reg_rdata : base_rdata;
    end
  end

endmodule

// File: design/dbg_scm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system control registers; answers in the same cycle as the strobe.
// resets are held while rst is high regardless of the vector.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module dbg_scm import dbg_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      reg_request,
  input  logic      reg_write,
  input  reg_addr_t reg_addr,
  input  reg_data_t reg_wdata,
  output logic      reg_err,
  output reg_data_t reg_rdata,
  output logic      sys_rst,
  output logic      cpu_rst
);

  // bit 0 system reset, bit 1 cpu reset.
  logic [1:0] rst_vec;

  assign sys_rst = rst_vec[0] | rst;
  assign cpu_rst = rst_vec[1] | rst;

  // register decode.
  always_comb begin
    reg_err   = 1'b0;
    reg_rdata = '0;
    case (reg_addr)
      SCM_BASE_ADDR:          reg_rdata = SYSTEM_VENDOR_ID;
      SCM_BASE_ADDR + 16'd1:  reg_rdata = SYSTEM_DEVICE_ID;
      SCM_BASE_ADDR + 16'd2:  reg_rdata = NUM_MOD;
      SCM_BASE_ADDR + 16'd3:  reg_rdata = MAX_PKT_LEN;
      RST_VEC_ADDR:           reg_rdata = {14'h0000, rst_vec};
      default:                reg_err   = reg_request;
    endcase
    // identity constants reject writes.
    if (reg_addr < RST_VEC_ADDR && reg_addr >= SCM_BASE_ADDR) begin
      reg_err = reg_request & reg_write;
    end
  end

  // new vector visible the cycle after the access.
  always_ff @(posedge clk) begin
    if (rst) begin
      rst_vec <= 2'b00;
    end else if (reg_request && reg_write && reg_addr == RST_VEC_ADDR) begin
      rst_vec <= reg_wdata[1:0];
    end
  end

endmodule

// File: design/dbg_scm_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debug system control module with its input buffer; id is static.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module dbg_scm_top import dbg_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] id,
  input  flit_data_t  debug_in_data,
  input  logic        debug_in_last,
  input  logic        debug_in_valid,
  output logic        debug_in_ready,
  output flit_data_t  debug_out_data,
  output logic        debug_out_last,
  output logic        debug_out_valid,
  input  logic        debug_out_ready,
  output logic        sys_rst,
  output logic        cpu_rst
);

  // buffer head toward the engine.
  flit_data_t fifo_data;
  logic       fifo_last;
  logic       fifo_valid;
  logic       fifo_ready;

  // register strobe.
  logic       reg_request;
  logic       reg_write;
  reg_addr_t  reg_addr;
  reg_data_t  reg_wdata;
  logic       reg_err;
  reg_data_t  reg_rdata;

  dbg_flit_fifo i_fifo (
    .clk            (clk),
    .rst            (rst),
    .debug_in_data  (debug_in_data),
    .debug_in_last  (debug_in_last),
    .debug_in_valid (debug_in_valid),
    .debug_in_ready (debug_in_ready),
    .fifo_data      (fifo_data),
    .fifo_last      (fifo_last),
    .fifo_valid     (fifo_valid),
    .fifo_ready     (fifo_ready)
  );

  dbg_reg_access i_reg_access (
    .clk             (clk),
    .rst             (rst),
    .id              (id),
    .fifo_data       (fifo_data),
    .fifo_last       (fifo_last),
    .fifo_valid      (fifo_valid),
    .fifo_ready      (fifo_ready),
    .debug_out_data  (debug_out_data),
    .debug_out_last  (debug_out_last),
    .debug_out_valid (debug_out_valid),
    .debug_out_ready (debug_out_ready),
    .reg_request     (reg_request),
    .reg_write       (reg_write),
    .reg_addr        (reg_addr),
    .reg_wdata       (reg_wdata),
    .reg_err         (reg_err),
    .reg_rdata       (reg_rdata)
  );

  dbg_scm i_scm (
    .clk         (clk),
    .rst         (rst),
    .reg_request (reg_request),
    .reg_write   (reg_write),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_err     (reg_err),
    .reg_rdata   (reg_rdata),
    .sys_rst     (sys_rst),
    .cpu_rst     (cpu_rst)
  );

endmodule

// File: test/dbg_scm_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound into dbg_scm_top; failures are also counted in fail_count.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module dbg_scm_props import dbg_pkg::*; (
  input logic       clk,
  input logic       rst,
  input flit_data_t debug_out_data,
  input logic       debug_out_last,
  input logic       debug_out_valid,
  input logic       debug_out_ready,
  input logic       sys_rst,
  input logic       cpu_rst
);

  int fail_count = 0;

  // stalled response flit keeps its word and last bit.
  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    debug_out_valid && !debug_out_ready |=>
      debug_out_valid && $stable(debug_out_data) && $stable(debug_out_last))
  else begin
    fail_count++;
    $error("response flit changed while the host stalled it");
  end

  // engine idle once a reset edge has passed.
  a_rst_valid: assert property (@(posedge clk) rst |=> !debug_out_valid)
  else begin
    fail_count++;
    $error("response valid seen after a reset edge");
  end

  // both reset outputs held in reset, then released with a cleared vector.
  a_rst_out: assert property (@(posedge clk)
    rst |=> (rst ? (sys_rst && cpu_rst) : (!sys_rst && !cpu_rst)))
  else begin
    fail_count++;
    $error("system or cpu reset not high in reset or not low right after it");
  end

endmodule

bind dbg_scm_top dbg_scm_props i_props (
  .clk             (clk),
  .rst             (rst),
  .debug_out_data  (debug_out_data),
  .debug_out_last  (debug_out_last),
  .debug_out_valid (debug_out_valid),
  .debug_out_ready (debug_out_ready),
  .sys_rst         (sys_rst),
  .cpu_rst         (cpu_rst)
);

// File: test/dbg_scm_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host model for dbg_scm_top with id 0x0005; responses checked in order.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module dbg_scm_tb import dbg_pkg::*; ();

  localparam logic [15:0] DUT_ID = 16'h0005;
  // packet count of the sequence below scales the watchdog.
  localparam int NUM_PKTS = 31;

  logic       clk;
  logic       rst;
  flit_data_t debug_in_data;
  logic       debug_in_last;
  logic       debug_in_valid;
  logic       debug_in_ready;
  flit_data_t debug_out_data;
  logic       debug_out_last;
  logic       debug_out_valid;
  logic       debug_out_ready;
  logic       sys_rst;
  logic       cpu_rst;

  int          seed = 32'h416f733d;
  int          errors = 0;
  int          checks = 0;
  logic [15:0] src_ctr = 16'h0040;
  // set once the input buffer has pushed back.
  logic        in_stalled = 1'b0;
  // expected response flits, oldest first.
  flit_data_t  exp_data[$];
  logic        exp_last[$];

  dbg_scm_top i_dut (
    .clk             (clk),
    .rst             (rst),
    .id              (DUT_ID),
    .debug_in_data   (debug_in_data),
    .debug_in_last   (debug_in_last),
    .debug_in_valid  (debug_in_valid),
    .debug_in_ready  (debug_in_ready),
    .debug_out_data  (debug_out_data),
    .debug_out_last  (debug_out_last),
    .debug_out_valid (debug_out_valid),
    .debug_out_ready (debug_out_ready),
    .sys_rst         (sys_rst),
    .cpu_rst         (cpu_rst)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_val(string name, logic [15:0] exp, logic [15:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %s exp=%h got=%h at %0t", name, exp, got, $time);
    end
  endtask

  // called 1 ns after an edge; handshake sampled mid cycle.
  task automatic send_flit(flit_data_t data, logic last);
    debug_in_data  = data;
    debug_in_last  = last;
    debug_in_valid = 1'b1;
    @(negedge clk);
    while (!debug_in_ready) begin
      in_stalled = 1'b1;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    debug_in_valid = 1'b0;
  endtask

  task automatic send_req(flit_data_t dest, logic write, reg_addr_t addr, reg_data_t wdata);
    send_flit(dest, 1'b0);
    send_flit(src_ctr, 1'b0);
    send_flit({TYPE_REG, write ? SUB_REQ_WRITE : SUB_REQ_READ, 10'h000}, 1'b0);
    send_flit(addr, !write);
    if (write) begin
      send_flit(wdata, 1'b1);
    end
  endtask

  // expected response is request src, own id, flags, then data on read success.
  task automatic push_resp(logic [3:0] sub, logic has_data, reg_data_t data);
    exp_data.push_back(src_ctr);
    exp_last.push_back(1'b0);
    exp_data.push_back(DUT_ID);
    exp_last.push_back(1'b0);
    exp_data.push_back({TYPE_REG, sub, 10'h000});
    exp_last.push_back(!has_data);
    if (has_data) begin
      exp_data.push_back(data);
      exp_last.push_back(1'b1);
    end
  endtask

  task automatic read_req(reg_addr_t addr, logic ok, reg_data_t data);
    src_ctr = src_ctr + 16'd1;
    push_resp(ok ? SUB_RESP_READ_OK : SUB_RESP_READ_ERR, ok, data);
    send_req(DUT_ID, 1'b0, addr, '0);
  endtask

  task automatic write_req(reg_addr_t addr, reg_data_t data, logic ok);
    src_ctr = src_ctr + 16'd1;
    push_resp(ok ? SUB_RESP_WRITE_OK : SUB_RESP_WRITE_ERR, 1'b0, '0);
    send_req(DUT_ID, 1'b1, addr, data);
  endtask

  // returns 1 ns after an edge once every response is in.
  task automatic wait_idle();
    while (exp_data.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  // random back-pressure and response checking.
  initial begin
    logic [31:0] rnd;
    debug_out_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      rnd = $random(seed);
      debug_out_ready = rnd[0];
      @(negedge clk);
      if (debug_out_valid && debug_out_ready) begin
        assert (exp_data.size() != 0) else begin
          errors++;
          $display("response flit %h arrived with no response outstanding", debug_out_data);
        end
        if (exp_data.size() != 0) begin
          check_val("debug_out_data", exp_data.pop_front(), debug_out_data);
          check_val("debug_out_last", 16'(exp_last.pop_front()), 16'(debug_out_last));
        end
      end
    end
  end

  initial begin
    repeat (NUM_PKTS * 200 + 10) @(posedge clk);
    $display("timeout: %0d responses flits still missing", exp_data.size());
    $display("RESULT: FAIL");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    rst            = 1'b1;
    debug_in_data  = '0;
    debug_in_last  = 1'b0;
    debug_in_valid = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    // empty buffer accepts flits while rst is held.
    check_val("debug_in_ready", 16'h0001, 16'(debug_in_ready));
    rst = 1'b0;

    // system identity.
    read_req(SCM_BASE_ADDR, 1'b1, SYSTEM_VENDOR_ID);
    read_req(SCM_BASE_ADDR + 16'd1, 1'b1, SYSTEM_DEVICE_ID);
    read_req(SCM_BASE_ADDR + 16'd2, 1'b1, NUM_MOD);
    read_req(SCM_BASE_ADDR + 16'd3, 1'b1, MAX_PKT_LEN);
    wait_idle();
    // module identity.
    read_req(16'h0000, 1'b1, MOD_VENDOR);
    read_req(16'h0001, 1'b1, MOD_TYPE);
    read_req(16'h0002, 1'b1, MOD_VERSION);
    wait_idle();

    // reset vector, bit 0 system and bit 1 cpu.
    for (int v = 0; v < 4; v++) begin
      write_req(RST_VEC_ADDR, 16'(v), 1'b1);
      wait_idle();
      check_val("sys_rst", 16'(v[0]), 16'(sys_rst));
      check_val("cpu_rst", 16'(v[1]), 16'(cpu_rst));
      read_req(RST_VEC_ADDR, 1'b1, 16'(v));
      wait_idle();
    end

    // unmapped read and write to a constant.
    read_req(16'h0300, 1'b0, '0);
    write_req(SCM_BASE_ADDR + 16'd1, 16'h1234, 1'b0);
    wait_idle();

    // foreign dest is dropped silently.
    send_req(16'h0009, 1'b0, SCM_BASE_ADDR, '0);
    read_req(SCM_BASE_ADDR + 16'd3, 1'b1, MAX_PKT_LEN);
    wait_idle();

    // back-to-back requests fill the buffer behind the responses.
    in_stalled = 1'b0;
    for (int i = 0; i < 3; i++) begin
      read_req(SCM_BASE_ADDR, 1'b1, SYSTEM_VENDOR_ID);
      write_req(RST_VEC_ADDR, 16'(i + 1), 1'b1);
      read_req(RST_VEC_ADDR, 1'b1, 16'(i + 1));
      read_req(16'h0001, 1'b1, MOD_TYPE);
    end
    wait_idle();
    assert (in_stalled) else begin
      errors++;
      $display("input buffer never pushed back during back-to-back requests");
    end
    repeat (4) @(posedge clk);

    $display("checks %0d, tb errors %0d, assertion failures %0d",
             checks, errors, i_dut.i_props.fail_count);
    if (errors == 0 && i_dut.i_props.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
